//--- logic/lc3b_macros.svh
`ifndef LC3B_MACROS_SVH
`define LC3B_MACROS_SVH

`define LC3B_WORD_W     16          // data word width
`define LC3B_NUM_REGS   8           // general registers r0..r7
`define LC3B_RESET_PC   16'h0000    // first fetch address
`define LC3B_NOP_WORD   16'h0000    // BR with empty nzp mask

`endif

//--- logic/lc3b_pkg.sv
`include "lc3b_macros.svh"

package lc3b_pkg;

typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
typedef logic [2:0] lc3b_reg;
typedef logic [2:0] lc3b_nzp;

typedef enum logic [3:0] {
    op_br   = 4'b0000,
    op_add  = 4'b0001,
    op_ldb  = 4'b0010,
    op_stb  = 4'b0011,
    op_jsr  = 4'b0100,
    op_and  = 4'b0101,
    op_ldr  = 4'b0110,
    op_str  = 4'b0111,
    op_rti  = 4'b1000,
    op_not  = 4'b1001,
    op_ldi  = 4'b1010,
    op_sti  = 4'b1011,
    op_jmp  = 4'b1100,
    op_shf  = 4'b1101,
    op_lea  = 4'b1110,
    op_trap = 4'b1111
} lc3b_opcode;

typedef enum logic [1:0] {
    alu_add  = 2'b00,
    alu_and  = 2'b01,
    alu_not  = 2'b10,
    alu_pass = 2'b11   // base plus offset
} alu_op_t;

typedef struct packed {
    lc3b_opcode opcode;
    alu_op_t    alu_op;
    logic       imm_select;     // b operand from imm
    logic       mem_read;
    logic       mem_write;
    logic       load_regfile;
    logic       load_cc;
    logic       is_branch;
    logic       is_nop;
    lc3b_nzp    nzp;            // branch condition mask
} lc3b_ctrl;

typedef struct packed {
    lc3b_ctrl ctrl;
    lc3b_word sr1_data;
    lc3b_word sr2_data;
    lc3b_reg  src1;
    lc3b_reg  src2;
    lc3b_reg  dest;
    lc3b_word imm;              // already extended and shifted
    lc3b_word pc_plus2;
} dec_exec_t;

typedef struct packed {
    lc3b_ctrl ctrl;
    lc3b_word alu_result;
    lc3b_word store_data;
    lc3b_word branch_target;
    lc3b_reg  dest;
} exec_mem_t;

typedef struct packed {
    logic     load_regfile;
    lc3b_reg  dest;
    lc3b_word result;
} mem_wb_t;

typedef struct packed {
    logic     read;
    lc3b_word addr;
} imem_req_t;

typedef struct packed {
    logic     read;
    logic     write;
    lc3b_word addr;
    lc3b_word wdata;
} dmem_req_t;

endpackage : lc3b_pkg

//--- logic/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder
(
    input lc3b_pkg::lc3b_word instr,
    output lc3b_pkg::lc3b_ctrl ctrl,
    output lc3b_pkg::lc3b_reg src1,
    output lc3b_pkg::lc3b_reg src2,
    output lc3b_pkg::lc3b_reg dest,
    output lc3b_pkg::lc3b_word imm
);

lc3b_pkg::lc3b_opcode opcode;
lc3b_pkg::lc3b_word sext5;
lc3b_pkg::lc3b_word adj6;
lc3b_pkg::lc3b_word adj9;

assign opcode = lc3b_pkg::lc3b_opcode'(instr[15:12]);
assign sext5 = {{11{instr[4]}}, instr[4:0]};
assign adj6 = {{9{instr[5]}}, instr[5:0], 1'b0};       // word offset to bytes
assign adj9 = {{6{instr[8]}}, instr[8:0], 1'b0};
assign dest = instr[11:9];
assign src1 = instr[8:6];

always_comb
begin
    ctrl = '0;
    ctrl.opcode = opcode;
    src2 = instr[2:0];
    imm = sext5;

    case (opcode)
        lc3b_pkg::op_add, lc3b_pkg::op_and:
        begin
            ctrl.alu_op = (opcode == lc3b_pkg::op_and) ? lc3b_pkg::alu_and
                                                       : lc3b_pkg::alu_add;
            ctrl.imm_select = instr[5];                // imm5 form
            ctrl.load_regfile = 1'b1;
            ctrl.load_cc = 1'b1;
        end

        lc3b_pkg::op_not:
        begin
            ctrl.alu_op = lc3b_pkg::alu_not;
            ctrl.load_regfile = 1'b1;
            ctrl.load_cc = 1'b1;
        end

        lc3b_pkg::op_ldr:
        begin
            ctrl.alu_op = lc3b_pkg::alu_pass;
            ctrl.imm_select = 1'b1;
            ctrl.mem_read = 1'b1;
            ctrl.load_regfile = 1'b1;
            ctrl.load_cc = 1'b1;
            imm = adj6;
        end

        lc3b_pkg::op_str:
        begin
            ctrl.alu_op = lc3b_pkg::alu_pass;
            ctrl.imm_select = 1'b1;
            ctrl.mem_write = 1'b1;
            src2 = instr[11:9];                        // store source sits in dest field
            imm = adj6;
        end

        lc3b_pkg::op_br:
        begin
            imm = adj9;
            if (instr[11:9] == 3'b000)
            begin
                // never taken, so this also covers the all-zero word
                ctrl.is_nop = 1'b1;
            end
            else
            begin
                ctrl.alu_op = lc3b_pkg::alu_pass;
                ctrl.imm_select = 1'b1;
                ctrl.is_branch = 1'b1;
                ctrl.nzp = instr[11:9];
            end
        end

        default:
        begin
            ctrl = '0;                                 // unsupported op runs as bubble
            ctrl.is_nop = 1'b1;
        end
    endcase
end

endmodule : instr_decoder

//--- logic/regfile.sv
`timescale 1ns/10ps
`include "lc3b_macros.svh"

module regfile
(
    input logic clk,
    input logic reset,
    input logic load,
    input lc3b_pkg::lc3b_reg dest,
    input lc3b_pkg::lc3b_word in,
    input lc3b_pkg::lc3b_reg src_a,
    input lc3b_pkg::lc3b_reg src_b,
    output lc3b_pkg::lc3b_word reg_a,
    output lc3b_pkg::lc3b_word reg_b
);

lc3b_pkg::lc3b_word data [`LC3B_NUM_REGS];

always_ff @(posedge clk)
begin
    if (reset)
    begin
        for (int i = 0; i < `LC3B_NUM_REGS; i++)
            data[i] <= '0;
    end
    else if (load)
    begin
        data[dest] <= in;
    end
end

// writeback value seen by decode in the same cycle
assign reg_a = (load && dest == src_a) ? in : data[src_a];
assign reg_b = (load && dest == src_b) ? in : data[src_b];

endmodule : regfile

//--- logic/alu.sv
`timescale 1ns/10ps

module alu
(
    input lc3b_pkg::alu_op_t op,
    input lc3b_pkg::lc3b_word a,
    input lc3b_pkg::lc3b_word b,
    output lc3b_pkg::lc3b_word f
);

always_comb
begin
    case (op)
        lc3b_pkg::alu_add:
            f = a + b;
        lc3b_pkg::alu_and:
            f = a & b;
        lc3b_pkg::alu_not:
            f = ~a;
        lc3b_pkg::alu_pass:
            f = a + b;          // address or branch target
        default:
            f = a;
    endcase
end

endmodule : alu

//--- logic/hazard_unit.sv
`timescale 1ns/10ps

module hazard_unit
(
    input lc3b_pkg::lc3b_ctrl exec_ctrl,
    input lc3b_pkg::lc3b_ctrl mem_ctrl,
    input logic wb_load,
    input lc3b_pkg::lc3b_reg dec_src1,
    input lc3b_pkg::lc3b_reg dec_src2,
    input lc3b_pkg::lc3b_reg exec_src1,
    input lc3b_pkg::lc3b_reg exec_src2,
    input lc3b_pkg::lc3b_reg exec_dest,
    input lc3b_pkg::lc3b_reg mem_dest,
    input lc3b_pkg::lc3b_reg wb_dest,
    output logic bubble,
    output logic [1:0] sel_a,
    output logic [1:0] sel_b
);

logic mem_fwd_ok;

// loaded data is not ready until writeback
assign mem_fwd_ok = mem_ctrl.load_regfile && !mem_ctrl.mem_read && !mem_ctrl.is_nop;

assign bubble = exec_ctrl.mem_read
                && (exec_dest == dec_src1 || exec_dest == dec_src2);

function automatic logic [1:0] fwd_select(input lc3b_pkg::lc3b_reg src);
    logic [1:0] sel;
    sel = 2'b00;                                   // registered operand
    if (mem_fwd_ok && mem_dest == src)
        sel = 2'b01;                               // newest result wins
    else if (wb_load && wb_dest == src)
        sel = 2'b10;
    return sel;
endfunction

always_comb
begin
    sel_a = fwd_select(exec_src1);
    sel_b = fwd_select(exec_src2);
end

endmodule : hazard_unit

//--- logic/pipe_stage_reg.sv
`timescale 1ns/10ps

module pipe_stage_reg
#(
    parameter type payload_t = logic
)
(
    input logic clk,
    input logic reset,
    input logic advance,
    input logic insert_bubble,
    input payload_t bubble_value,
    input payload_t in,
    output payload_t out
);

always_ff @(posedge clk)
begin
    if (reset)
    begin
        out <= bubble_value;
    end
    else if (advance)
    begin
        if (insert_bubble)
            out <= bubble_value;   // squash or load-use gap
        else
            out <= in;
    end
end

endmodule : pipe_stage_reg

//--- logic/lc3b_pipeline.sv
`timescale 1ns/10ps
`include "lc3b_macros.svh"

module lc3b_pipeline
(
    input logic clk,
    input logic reset,
    output lc3b_pkg::imem_req_t imem_req,
    input lc3b_pkg::lc3b_word instr_rdata,
    input logic instr_resp,
    output lc3b_pkg::dmem_req_t dmem_req,
    input lc3b_pkg::lc3b_word mem_rdata,
    input logic mem_resp
);

localparam lc3b_pkg::lc3b_ctrl ctrl_bubble = '{opcode: lc3b_pkg::op_br,
                                              alu_op: lc3b_pkg::alu_add,
                                              is_nop: 1'b1,
                                              default: '0};
localparam lc3b_pkg::dec_exec_t de_bubble = '{ctrl: ctrl_bubble, default: '0};
localparam lc3b_pkg::exec_mem_t em_bubble = '{ctrl: ctrl_bubble, default: '0};
localparam lc3b_pkg::mem_wb_t mw_bubble = '0;

lc3b_pkg::lc3b_word pc;
lc3b_pkg::lc3b_word ir;
lc3b_pkg::lc3b_nzp cc;
lc3b_pkg::lc3b_nzp cc_next;

logic advance;
logic flush;
logic bubble;
logic pc_load;
logic dmem_access;
logic imem_done;
logic dmem_done;
lc3b_pkg::lc3b_word instr_hold;
lc3b_pkg::lc3b_word rdata_hold;
lc3b_pkg::lc3b_word fetched;
lc3b_pkg::lc3b_word load_data;

lc3b_pkg::lc3b_ctrl dec_ctrl;
lc3b_pkg::lc3b_reg dec_src1;
lc3b_pkg::lc3b_reg dec_src2;
lc3b_pkg::lc3b_reg dec_dest;
lc3b_pkg::lc3b_word dec_imm;
lc3b_pkg::lc3b_word reg_a;
lc3b_pkg::lc3b_word reg_b;

lc3b_pkg::dec_exec_t de_in;
lc3b_pkg::dec_exec_t de_out;
lc3b_pkg::exec_mem_t em_in;
lc3b_pkg::exec_mem_t em_out;
lc3b_pkg::mem_wb_t mw_in;
lc3b_pkg::mem_wb_t mw_out;

logic [1:0] sel_a;
logic [1:0] sel_b;
lc3b_pkg::lc3b_word fwd_a;
lc3b_pkg::lc3b_word fwd_b;
lc3b_pkg::lc3b_word alu_a;
lc3b_pkg::lc3b_word alu_b;
lc3b_pkg::lc3b_word alu_f;

// a strobe that arrives early is kept until the whole pipe can move
assign dmem_access = em_out.ctrl.mem_read || em_out.ctrl.mem_write;
assign advance = (instr_resp || imem_done) && (!dmem_access || mem_resp || dmem_done);
assign flush = em_out.ctrl.is_branch && |(em_out.ctrl.nzp & cc);
assign pc_load = advance && (flush || !bubble);
assign fetched = imem_done ? instr_hold : instr_rdata;
assign load_data = dmem_done ? rdata_hold : mem_rdata;

assign imem_req = '{read: 1'b1, addr: pc};
assign dmem_req = '{read: em_out.ctrl.mem_read && !dmem_done,
                    write: em_out.ctrl.mem_write && !dmem_done,
                    addr: em_out.alu_result,
                    wdata: em_out.store_data};

always_ff @(posedge clk)
begin
    if (reset)
    begin
        imem_done <= 1'b0;
        dmem_done <= 1'b0;
    end
    else
    begin
        if (pc_load)
            imem_done <= 1'b0;              // fetch consumed, new address
        else if (instr_resp)
            imem_done <= 1'b1;
        if (advance)
            dmem_done <= 1'b0;
        else if (mem_resp && dmem_access)
            dmem_done <= 1'b1;
    end
end

always_ff @(posedge clk)
begin
    if (instr_resp)
        instr_hold <= instr_rdata;
    if (mem_resp)
        rdata_hold <= mem_rdata;
end

always_ff @(posedge clk)
begin
    if (reset)
    begin
        pc <= `LC3B_RESET_PC;
        ir <= `LC3B_NOP_WORD;
        cc <= 3'b010;                       // z
    end
    else if (advance)
    begin
        if (flush)
        begin
            pc <= em_out.branch_target;
            ir <= `LC3B_NOP_WORD;           // drop wrong-path fetch
        end
        else if (!bubble)
        begin
            pc <= pc + 16'd2;
            ir <= fetched;
        end
        if (em_out.ctrl.load_cc)
            cc <= cc_next;                  // value headed into writeback
    end
end

always_comb
begin
    if (mw_in.result[`LC3B_WORD_W-1])
        cc_next = 3'b100;
    else if (mw_in.result == '0)
        cc_next = 3'b010;
    else
        cc_next = 3'b001;
end

instr_decoder decoder
(
    .instr(ir),
    .ctrl(dec_ctrl),
    .src1(dec_src1),
    .src2(dec_src2),
    .dest(dec_dest),
    .imm(dec_imm)
);

regfile regs
(
    .clk(clk),
    .reset(reset),
    .load(mw_out.load_regfile && advance),
    .dest(mw_out.dest),
    .in(mw_out.result),
    .src_a(dec_src1),
    .src_b(dec_src2),
    .reg_a(reg_a),
    .reg_b(reg_b)
);

hazard_unit hazards
(
    .exec_ctrl(de_out.ctrl),
    .mem_ctrl(em_out.ctrl),
    .wb_load(mw_out.load_regfile),
    .dec_src1(dec_src1),
    .dec_src2(dec_src2),
    .exec_src1(de_out.src1),
    .exec_src2(de_out.src2),
    .exec_dest(de_out.dest),
    .mem_dest(em_out.dest),
    .wb_dest(mw_out.dest),
    .bubble(bubble),
    .sel_a(sel_a),
    .sel_b(sel_b)
);

// pc already points past the instruction in ir
assign de_in = '{ctrl: dec_ctrl, sr1_data: reg_a, sr2_data: reg_b, src1: dec_src1,
                 src2: dec_src2, dest: dec_dest, imm: dec_imm, pc_plus2: pc};

pipe_stage_reg #(.payload_t(lc3b_pkg::dec_exec_t)) dec_exec
(
    .clk(clk),
    .reset(reset),
    .advance(advance),
    .insert_bubble(bubble || flush),
    .bubble_value(de_bubble),
    .in(de_in),
    .out(de_out)
);

function automatic lc3b_pkg::lc3b_word fwd_mux(input logic [1:0] sel,
                                               input lc3b_pkg::lc3b_word reg_val);
    case (sel)
        2'b01:
            return em_out.alu_result;
        2'b10:
            return mw_out.result;
        default:
            return reg_val;
    endcase
endfunction

always_comb
begin
    fwd_a = fwd_mux(sel_a, de_out.sr1_data);
    fwd_b = fwd_mux(sel_b, de_out.sr2_data);
    alu_a = (de_out.ctrl.opcode == lc3b_pkg::op_br) ? de_out.pc_plus2 : fwd_a;
    alu_b = de_out.ctrl.imm_select ? de_out.imm : fwd_b;
end

alu alu_unit
(
    .op(de_out.ctrl.alu_op),
    .a(alu_a),
    .b(alu_b),
    .f(alu_f)
);

assign em_in = '{ctrl: de_out.ctrl, alu_result: alu_f, store_data: fwd_b,
                 branch_target: alu_f, dest: de_out.dest};

pipe_stage_reg #(.payload_t(lc3b_pkg::exec_mem_t)) exec_mem
(
    .clk(clk),
    .reset(reset),
    .advance(advance),
    .insert_bubble(flush),
    .bubble_value(em_bubble),
    .in(em_in),
    .out(em_out)
);

assign mw_in = '{load_regfile: em_out.ctrl.load_regfile,
                 dest: em_out.dest,
                 result: em_out.ctrl.mem_read ? load_data : em_out.alu_result};

pipe_stage_reg #(.payload_t(lc3b_pkg::mem_wb_t)) mem_wb
(
    .clk(clk),
    .reset(reset),
    .advance(advance),
    .insert_bubble(1'b0),
    .bubble_value(mw_bubble),
    .in(mw_in),
    .out(mw_out)
);

endmodule : lc3b_pipeline

//--- test/lc3b_pipeline_properties.sv
`timescale 1ns/10ps

module lc3b_pipeline_properties
(
    input logic clk,
    input logic reset,
    input lc3b_pkg::imem_req_t imem_req,
    input logic instr_resp,
    input lc3b_pkg::dmem_req_t dmem_req,
    input logic mem_resp
);

localparam lc3b_pkg::lc3b_word poison_addr = 16'h003e;   // wrong-path store target

int fail_count = 0;
lc3b_pkg::imem_req_t fetch_prev;    // fetch request one cycle back
logic fetch_answered;               // strobe seen since the address last moved
logic fetch_waiting;

assign fetch_waiting = !instr_resp && (!fetch_answered || imem_req != fetch_prev);

always_ff @(posedge clk)
begin
    fetch_prev <= imem_req;
    if (reset)
        fetch_answered <= 1'b0;
    else if (instr_resp)
        fetch_answered <= 1'b1;
    else if (imem_req != fetch_prev)
        fetch_answered <= 1'b0;         // new address needs its own strobe
end

// data request held while waiting for its strobe
dmem_hold: assert property (@(posedge clk) disable iff (reset)
    (dmem_req.read || dmem_req.write) && !mem_resp |=> $stable(dmem_req))
else
begin
    $error("data request changed before its response");
    fail_count++;
end

// fetch address held until the instruction arrives
imem_hold: assert property (@(posedge clk) disable iff (reset)
    fetch_waiting |=> $stable(imem_req))
else
begin
    $error("fetch request changed before its response");
    fail_count++;
end

// stage registers are bubbles in reset and just after
reset_quiet: assert property (@(posedge clk)
    $past(reset) |-> !dmem_req.read && !dmem_req.write)
else
begin
    $error("data access during or right after reset");
    fail_count++;
end

fetch_after_reset: assert property (@(posedge clk)
    $fell(reset) |-> imem_req.read && imem_req.addr == 16'h0000)
else
begin
    $error("first fetch after reset not at reset address");
    fail_count++;
end

no_wrong_path: assert property (@(posedge clk) disable iff (reset)
    dmem_req.write |-> dmem_req.addr != poison_addr)
else
begin
    $error("flushed store reached the data bus");
    fail_count++;
end

endmodule : lc3b_pipeline_properties

bind lc3b_pipeline lc3b_pipeline_properties props
(
    .clk(clk),
    .reset(reset),
    .imem_req(imem_req),
    .instr_resp(instr_resp),
    .dmem_req(dmem_req),
    .mem_resp(mem_resp)
);

//--- test/tb_lc3b_pipeline.sv
`timescale 1ns/10ps

module tb_lc3b_pipeline;

localparam int PROG_LEN = 21;
localparam int NUM_STORES = 6;
localparam int NUM_TESTS = 3;
localparam int CYCLE_LIMIT = 30 * PROG_LEN;

logic clk = 1'b0;
logic reset = 1'b1;
lc3b_pkg::imem_req_t imem_req;
lc3b_pkg::lc3b_word instr_rdata = '0;
logic instr_resp = 1'b0;
lc3b_pkg::dmem_req_t dmem_req;
lc3b_pkg::lc3b_word mem_rdata = '0;
logic mem_resp = 1'b0;

logic [15:0] prog [PROG_LEN];
logic [15:0] dmem [64];
logic [31:0] lcg_state = 32'd41135;
logic [15:0] last_iaddr;
logic i_pend;
logic [1:0] i_wait;
logic d_busy;
logic [1:0] d_wait;

lc3b_pkg::lc3b_word exp_addr [NUM_STORES];
lc3b_pkg::lc3b_word exp_data [NUM_STORES];
int sec_last [NUM_TESTS];
string test_name [NUM_TESTS];
int store_idx = 0;
int test_idx = 0;
int errors = 0;
int sec_errors = 0;
int tests_failed = 0;
int cycles = 0;
int fails;

lc3b_pipeline dut
(
    .clk(clk),
    .reset(reset),
    .imem_req(imem_req),
    .instr_rdata(instr_rdata),
    .instr_resp(instr_resp),
    .dmem_req(dmem_req),
    .mem_rdata(mem_rdata),
    .mem_resp(mem_resp)
);

initial
begin
    forever #2 clk = ~clk;
end

function automatic logic [1:0] next_delay();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[17:16];
endfunction

function automatic logic [15:0] fill_word(input int idx);
    return 16'h0101 * idx[15:0] + 16'h0042;
endfunction

initial
begin
    prog[0] = 16'h1225;     // ADD r1, r0, #5
    prog[1] = 16'h1463;     // ADD r2, r1, #3
    prog[2] = 16'h1642;     // ADD r3, r1, r2
    prog[3] = 16'h7601;     // STR r3, r0, #1
    prog[4] = 16'h58e6;     // AND r4, r3, #6
    prog[5] = 16'h9b3f;     // NOT r5, r4
    prog[6] = 16'h7a02;     // STR r5, r0, #2
    prog[7] = 16'h5d42;     // AND r6, r5, r2
    prog[8] = 16'h7c03;     // STR r6, r0, #3
    prog[9] = 16'h620a;     // LDR r1, r0, #10
    prog[10] = 16'h1467;    // ADD r2, r1, #7
    prog[11] = 16'h7404;    // STR r2, r0, #4
    prog[12] = 16'h660b;    // LDR r3, r0, #11
    prog[13] = 16'h7605;    // STR r3, r0, #5
    prog[14] = 16'h5e20;    // AND r7, r0, #0 sets z
    prog[15] = 16'h0403;    // BRz +3, taken
    prog[16] = 16'h7a1f;    // wrong path, STR r5 to word 31
    prog[17] = 16'h7a1f;
    prog[18] = 16'h7a1f;
    prog[19] = 16'h0801;    // BRn +1, not taken
    prog[20] = 16'h7406;    // STR r2, r0, #6

    exp_addr[0] = 16'h0002;
    exp_data[0] = 16'h000d;     // 5 + 8
    exp_addr[1] = 16'h0004;
    exp_data[1] = 16'hfffb;     // ~(13 & 6)
    exp_addr[2] = 16'h0006;
    exp_data[2] = 16'h0008;     // fffb & 8
    exp_addr[3] = 16'h0008;
    exp_data[3] = fill_word(10) + 16'd7;
    exp_addr[4] = 16'h000a;
    exp_data[4] = fill_word(11);
    exp_addr[5] = 16'h000c;
    exp_data[5] = fill_word(10) + 16'd7;

    sec_last[0] = 2;
    sec_last[1] = 4;
    sec_last[2] = 5;
    test_name[0] = "alu_forwarding";
    test_name[1] = "load_use";
    test_name[2] = "branch_flush";
end

// instruction and data memory models share one random stream
always @(posedge clk)
begin
    instr_resp <= 1'b0;
    mem_resp <= 1'b0;
    if (reset)
    begin
        last_iaddr <= 16'hffff;        // forces a fetch after reset
        i_pend <= 1'b0;
        d_busy <= 1'b0;
        for (int i = 0; i < 64; i++)
            dmem[i] <= fill_word(i);
    end
    else
    begin
        if (imem_req.addr != last_iaddr)
        begin
            last_iaddr <= imem_req.addr;
            i_pend <= 1'b1;
            i_wait <= next_delay() % 2'd3;
        end
        else if (i_pend)
        begin
            if (i_wait == 0)
            begin
                instr_resp <= 1'b1;
                instr_rdata <= (imem_req.addr[15:1] < PROG_LEN)
                               ? prog[imem_req.addr[15:1]] : 16'h0000;
                i_pend <= 1'b0;
            end
            else
                i_wait <= i_wait - 2'd1;
        end

        if (d_busy)
        begin
            if (d_wait == 0)
            begin
                mem_resp <= 1'b1;
                mem_rdata <= dmem[dmem_req.addr[6:1]];
                if (dmem_req.write)
                    dmem[dmem_req.addr[6:1]] <= dmem_req.wdata;
                d_busy <= 1'b0;
            end
            else
                d_wait <= d_wait - 2'd1;
        end
        else if ((dmem_req.read || dmem_req.write) && !mem_resp)
        begin
            d_busy <= 1'b1;
            d_wait <= next_delay();
        end
    end
end

// every accepted store is compared with the next expected one
always @(posedge clk)
begin
    if (!reset && dmem_req.write && mem_resp)
    begin
        if (store_idx >= NUM_STORES)
        begin
            $display("store to address %h after the last expected store", dmem_req.addr);
            errors++;
        end
        else
        begin
            assert (dmem_req.addr == exp_addr[store_idx])
            else
            begin
                $display("mismatch at %0t: dmem_req.addr expected %h got %h",
                         $time, exp_addr[store_idx], dmem_req.addr);
                errors++;
            end
            assert (dmem_req.wdata == exp_data[store_idx])
            else
            begin
                $display("mismatch at %0t: dmem_req.wdata expected %h got %h",
                         $time, exp_data[store_idx], dmem_req.wdata);
                errors++;
            end
            if (store_idx == sec_last[test_idx])
            begin
                if (errors + dut.props.fail_count != sec_errors)
                    tests_failed++;
                $display("test %0s: %0s", test_name[test_idx],
                         (errors + dut.props.fail_count == sec_errors) ? "ok" : "FAILED");
                sec_errors = errors + dut.props.fail_count;
                test_idx++;
            end
        end
        store_idx++;
    end
end

always @(posedge clk)
begin
    cycles <= cycles + 1;
end

initial
begin
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    while (store_idx < NUM_STORES && cycles < CYCLE_LIMIT)
        @(posedge clk);
    repeat (8) @(posedge clk);      // late wrong-path writes would show here
    fails = errors + dut.props.fail_count;
    $display("tests: %0d run, %0d failed, %0d check errors, %0d of %0d stores",
             test_idx, tests_failed, fails, store_idx, NUM_STORES);
    if (store_idx == NUM_STORES && fails == 0)
    begin
        $display("Simulation passed");
    end
    else
    begin
        if (store_idx < NUM_STORES)
            $display("timeout after %0d cycles waiting for stores", cycles);
        $display("Simulation failed");
    end
    $finish;
end

endmodule : tb_lc3b_pipeline

//--- sim.f
+incdir+logic
logic/lc3b_pkg.sv
logic/instr_decoder.sv
logic/regfile.sv
logic/alu.sv
logic/hazard_unit.sv
logic/pipe_stage_reg.sv
logic/lc3b_pipeline.sv
test/lc3b_pipeline_properties.sv
test/tb_lc3b_pipeline.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_lc3b_pipeline
FILELIST = sim.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)
